// ==== sim.f ====
+incdir+include
rtl/trk_pipe_pkg.sv
rtl/trk_apb_pkg.sv
rtl/trk_retire_if.sv
rtl/trk_pipeline.sv
rtl/trk_retire_fifo.sv
rtl/trk_apb_regs.sv
rtl/trk_top.sv
bench/tb_trk_top.sv

// ==== Bender.yml ====
package:
  name: trk_tracker

export_include_dirs:
  - include

sources:
  - files:
      - rtl/trk_pipe_pkg.sv
      - rtl/trk_apb_pkg.sv
      - rtl/trk_retire_if.sv
      - rtl/trk_pipeline.sv
      - rtl/trk_retire_fifo.sv
      - rtl/trk_apb_regs.sv
      - rtl/trk_top.sv
  - target: test
    files:
      - bench/tb_trk_top.sv

// ==== bench/trk_trace.txt ====
# C: pc instr id_valid is_decoding is_illegal ex_valid misaligned apu_en apu_rvalid
#    ex_we ex_addr ex_wdata wb_valid wb_we wb_addr wb_wdata req gnt dwe daddr dwdata
# E: pc instr rd_addr rd_data rd_written mem_valid mem_we mem_addr mem_data misaligned
# S: count overflow empty
# ALU, load, store, mret and an ALU after it
C 100 00a00093 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
C 104 0000a103 1 1 0 1 0 0 0 1 1 a 0 0 0 0 0 0 0 0 0
C 108 0020a223 1 1 0 1 0 0 0 0 0 0 1 0 0 0 1 1 0 1000 0
C 10c 30200073 1 1 0 1 0 0 0 0 0 0 1 1 2 12345678 1 1 1 2004 12345678
C 110 00300193 1 1 0 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
C 114 003100d3 1 1 0 1 0 0 0 1 3 3 1 0 0 0 0 0 0 0 0
# APU offload parked, younger ALU waits in EX
C 0 0 0 0 0 1 0 1 0 0 0 0 1 0 0 0 0 0 0 0 0
C 118 00400213 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
C 0 0 0 0 0 0 0 0 0 1 4 4 0 0 0 0 0 0 0 0 0
C 11c 004020a3 1 1 0 1 0 0 1 1 1 3f800000 0 0 0 0 0 0 0 0 0
# Misaligned store stays one extra cycle in EX
C 0 0 0 0 0 1 1 0 0 0 0 0 1 0 0 0 1 1 1 1 4
C 120 00500293 1 1 0 1 0 0 0 0 0 0 1 0 0 0 1 1 1 4 0
C 124 00600313 1 1 0 1 0 0 0 1 5 5 1 0 0 0 0 0 0 0 0
C 0 0 0 0 0 1 0 0 0 1 6 6 1 0 0 0 0 0 0 0 0
C 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
C 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Queue is full, the last two records were dropped
S 8 1 0
E 100 00a00093 1 a 1 0 0 0 0 0
E 104 0000a103 2 12345678 1 1 0 1000 0 0
E 108 0020a223 0 0 0 1 1 2004 12345678 0
E 10c 30200073 0 0 0 0 0 0 0 0
E 110 00300193 3 3 1 0 0 0 0 0
E 114 003100d3 1 3f800000 1 0 0 0 0 0
E 118 00400213 4 4 1 0 0 0 0 0
E 11c 004020a3 0 0 0 1 1 1 4 1
S 0 1 1

// ==== bench/tb_trk_top.sv ====
// Retirement tracker testbench
// Replays core activity from a trace file, then reads the retire queue
// over APB and compares every record and status word with the trace

`default_nettype none

`include "trk_config.svh"

module tb_trk_top;

  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk_i = 1'b0;
  logic                   rst_n;
  logic [`TRK_XLEN-1:0]   pc_i, instr_i;
  logic                   id_valid_i, is_decoding_i, is_illegal_i;
  logic                   ex_valid_i, data_misaligned_i, apu_en_i, apu_rvalid_i;
  logic                   ex_reg_we_i, wb_valid_i, wb_reg_we_i;
  logic [`TRK_REG_AW-1:0] ex_reg_addr_i, wb_reg_addr_i;
  logic [`TRK_XLEN-1:0]   ex_reg_wdata_i, wb_reg_wdata_i;
  logic                   ex_data_req_i, ex_data_gnt_i, ex_data_we_i;
  logic [`TRK_XLEN-1:0]   ex_data_addr_i, ex_data_wdata_i;
  logic                   psel_i, penable_i, pwrite_i;
  logic [`TRK_APB_AW-1:0] paddr_i;
  logic [`TRK_XLEN-1:0]   pwdata_i, prdata_o;
  logic                   pready_o, pslverr_o;

  // One C line of the trace, column 0 at index 0
  typedef logic [20:0][31:0] stim_row_t;

  stim_row_t                 stim_q[$];
  trk_pipe_pkg::retire_rec_t exp_rec_q[$];
  trk_apb_pkg::trk_status_t  exp_stat_q[$];
  bit                        is_rec_q[$];
  bit                        trace_loaded = 1'b0;

  trk_top UUT (.*);

  always #2 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic flag_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic check_rec(trk_pipe_pkg::retire_rec_t exp, trk_pipe_pkg::retire_rec_t act);
    if (act.pc !== exp.pc) flag_mismatch("rec.pc", exp.pc, act.pc);
    if (act.instr !== exp.instr) flag_mismatch("rec.instr", exp.instr, act.instr);
    if (act.rd_addr !== exp.rd_addr)
      flag_mismatch("rec.rd_addr", 32'(exp.rd_addr), 32'(act.rd_addr));
    if (act.rd_data !== exp.rd_data) flag_mismatch("rec.rd_data", exp.rd_data, act.rd_data);
    if (act.rd_written !== exp.rd_written)
      flag_mismatch("rec.rd_written", 32'(exp.rd_written), 32'(act.rd_written));
    if (act.mem_valid !== exp.mem_valid)
      flag_mismatch("rec.mem_valid", 32'(exp.mem_valid), 32'(act.mem_valid));
    if (act.mem_we !== exp.mem_we)
      flag_mismatch("rec.mem_we", 32'(exp.mem_we), 32'(act.mem_we));
    if (act.mem_addr !== exp.mem_addr)
      flag_mismatch("rec.mem_addr", exp.mem_addr, act.mem_addr);
    if (act.mem_data !== exp.mem_data)
      flag_mismatch("rec.mem_data", exp.mem_data, act.mem_data);
    if (act.misaligned !== exp.misaligned)
      flag_mismatch("rec.misaligned", 32'(exp.misaligned), 32'(act.misaligned));
  endtask

  task automatic check_status(trk_apb_pkg::trk_status_t exp, trk_apb_pkg::trk_status_t act);
    if (act !== exp) flag_mismatch("status", exp, act);
  endtask

  task automatic check_slverr(string what, logic exp, logic act);
    if (act !== exp) flag_mismatch({"pslverr_o on ", what}, 32'(exp), 32'(act));
  endtask

  task automatic check_ready(logic exp, logic act);
    if (act !== exp) flag_mismatch("pready_o", 32'(exp), 32'(act));
  endtask

  // --------------------------------------------------------------------------
  // Trace loading
  // --------------------------------------------------------------------------
  task automatic load_trace();
    int                        fd;
    int                        code;
    int                        want;
    logic [8*8-1:0]            tag;
    logic [8*200-1:0]          line;
    stim_row_t                 row;
    logic [9:0][31:0]          f;
    trk_pipe_pkg::retire_rec_t rec;
    trk_apb_pkg::trk_status_t  stat;
    fd = $fopen("bench/trk_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file bench/trk_trace.txt");
      abort_run();
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "C") begin
        want = 21;
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       row[0], row[1], row[2], row[3], row[4], row[5], row[6], row[7],
                       row[8], row[9], row[10], row[11], row[12], row[13], row[14],
                       row[15], row[16], row[17], row[18], row[19], row[20]);
        stim_q.push_back(row);
      end else if (tag == "E") begin
        want = 10;
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                       f[4], f[5], f[6], f[7], f[8], f[9]);
        rec.pc         = f[0];
        rec.instr      = f[1];
        rec.rd_addr    = f[2][`TRK_REG_AW-1:0];
        rec.rd_data    = f[3];
        rec.rd_written = f[4][0];
        rec.mem_valid  = f[5][0];
        rec.mem_we     = f[6][0];
        rec.mem_addr   = f[7];
        rec.mem_data   = f[8];
        rec.misaligned = f[9][0];
        exp_rec_q.push_back(rec);
        is_rec_q.push_back(1'b1);
      end else if (tag == "S") begin
        want = 3;
        code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
        stat          = '0;
        stat.count    = f[0][3:0];
        stat.overflow = f[1][0];
        stat.empty    = f[2][0];
        exp_stat_q.push_back(stat);
        is_rec_q.push_back(1'b0);
      end else begin
        // Comment line, skip the rest of it
        code = $fgets(line, fd);
        want = code;
      end
      if (code != want) begin
        $display("Malformed line in the trace file, tag %0s", tag);
        abort_run();
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------------------------------
  // Core and APB drivers
  // --------------------------------------------------------------------------
  task automatic drive_core(stim_row_t r);
    pc_i              <= r[0];
    instr_i           <= r[1];
    id_valid_i        <= r[2][0];
    is_decoding_i     <= r[3][0];
    is_illegal_i      <= r[4][0];
    ex_valid_i        <= r[5][0];
    data_misaligned_i <= r[6][0];
    apu_en_i          <= r[7][0];
    apu_rvalid_i      <= r[8][0];
    ex_reg_we_i       <= r[9][0];
    ex_reg_addr_i     <= r[10][`TRK_REG_AW-1:0];
    ex_reg_wdata_i    <= r[11];
    wb_valid_i        <= r[12][0];
    wb_reg_we_i       <= r[13][0];
    wb_reg_addr_i     <= r[14][`TRK_REG_AW-1:0];
    wb_reg_wdata_i    <= r[15];
    ex_data_req_i     <= r[16][0];
    ex_data_gnt_i     <= r[17][0];
    ex_data_we_i      <= r[18][0];
    ex_data_addr_i    <= r[19];
    ex_data_wdata_i   <= r[20];
  endtask

  task automatic apb_xfer(input logic wr, input logic [`TRK_APB_AW-1:0] addr,
                          input logic [`TRK_XLEN-1:0] wdata,
                          output logic [`TRK_XLEN-1:0] rdata, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // Zero-wait slave, response settles mid access phase
    @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    check_ready(1'b1, pready_o);
  endtask

  task automatic bus_idle(int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
    end
  endtask

  task automatic read_reg(input logic [`TRK_APB_AW-1:0] addr, input string name,
                          output logic [`TRK_XLEN-1:0] data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_slverr(name, 1'b0, err);
  endtask

  task automatic read_status_check(trk_apb_pkg::trk_status_t exp);
    logic [`TRK_XLEN-1:0] w;
    read_reg(`TRK_OFS_STATUS, "STATUS read", w);
    check_status(exp, trk_apb_pkg::trk_status_t'(w));
  endtask

  // Fetch every field of the head, compare, then pop it
  task automatic read_record_check(trk_pipe_pkg::retire_rec_t exp);
    logic [`TRK_XLEN-1:0]      w;
    logic                      err;
    trk_pipe_pkg::retire_rec_t act;
    read_reg(`TRK_OFS_PC, "PC read", w);
    act.pc = w;
    read_reg(`TRK_OFS_INSTR, "INSTR read", w);
    act.instr = w;
    read_reg(`TRK_OFS_RD, "RD read", w);
    act.rd_addr    = w[`TRK_REG_AW-1:0];
    act.rd_written = w[`TRK_REG_AW];
    act.mem_valid  = w[`TRK_REG_AW+1];
    act.mem_we     = w[`TRK_REG_AW+2];
    act.misaligned = w[`TRK_REG_AW+3];
    read_reg(`TRK_OFS_RD_DATA, "RD_DATA read", w);
    act.rd_data = w;
    read_reg(`TRK_OFS_MEM_ADDR, "MEM_ADDR read", w);
    act.mem_addr = w;
    read_reg(`TRK_OFS_MEM_DATA, "MEM_DATA read", w);
    act.mem_data = w;
    check_rec(exp, act);
    apb_xfer(1'b1, `TRK_OFS_POP, 32'h0, w, err);
    check_slverr("POP write", 1'b0, err);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [`TRK_XLEN-1:0] w;
    logic                 err;
    void'($urandom(32'h126a));
    rst_n     = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    drive_core('0);
    load_trace();
    trace_loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_n <= 1'b1;
    @(negedge clk_i);
    check_slverr("idle bus after reset", 1'b0, pslverr_o);

    foreach (stim_q[i]) begin
      @(posedge clk_i);
      drive_core(stim_q[i]);
    end
    @(posedge clk_i);
    drive_core('0);
    repeat (2) @(posedge clk_i);

    foreach (is_rec_q[i]) begin
      if (is_rec_q[i]) begin
        read_record_check(exp_rec_q.pop_front());
        bus_idle($urandom % 4);
      end else begin
        read_status_check(exp_stat_q.pop_front());
      end
    end

    // Illegal accesses
    apb_xfer(1'b0, `TRK_OFS_POP, '0, w, err);
    check_slverr("read of POP", 1'b1, err);
    apb_xfer(1'b0, 8'h20, '0, w, err);
    check_slverr("read of unused offset 0x20", 1'b1, err);
    apb_xfer(1'b1, `TRK_OFS_STATUS, 32'h1, w, err);
    check_slverr("write to STATUS", 1'b1, err);
    bus_idle(1);

    $display("All checks passed");
    $finish;
  end

  // Watchdog, sized from the trace length
  initial begin
    int unsigned limit_ns;
    wait (trace_loaded);
    limit_ns = 4 * (stim_q.size() + 20 * exp_rec_q.size()) + 200;
    #(limit_ns * 1ns);
    $display("Timeout, the run did not finish within %0d ns", limit_ns);
    abort_run();
  end

endmodule

`default_nettype wire

// ==== rtl/trk_top.sv ====
// Retirement tracker top level
// Watches the core's decode, EX and WB signals, queues one record per
// retired instruction in program order and lets a host read them over APB

`default_nettype none

`include "trk_config.svh"

module trk_top (
  input  logic                   clk_i,
  input  logic                   rst_n,
  // Core observation
  input  logic [`TRK_XLEN-1:0]   pc_i,
  input  logic [`TRK_XLEN-1:0]   instr_i,
  input  logic                   id_valid_i,
  input  logic                   is_decoding_i,
  input  logic                   is_illegal_i,
  input  logic                   ex_valid_i,
  input  logic                   data_misaligned_i,
  input  logic                   apu_en_i,
  input  logic                   apu_rvalid_i,
  input  logic                   ex_reg_we_i,
  input  logic [`TRK_REG_AW-1:0] ex_reg_addr_i,
  input  logic [`TRK_XLEN-1:0]   ex_reg_wdata_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_reg_we_i,
  input  logic [`TRK_REG_AW-1:0] wb_reg_addr_i,
  input  logic [`TRK_XLEN-1:0]   wb_reg_wdata_i,
  input  logic                   ex_data_req_i,
  input  logic                   ex_data_gnt_i,
  input  logic                   ex_data_we_i,
  input  logic [`TRK_XLEN-1:0]   ex_data_addr_i,
  input  logic [`TRK_XLEN-1:0]   ex_data_wdata_i,
  // APB host port
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`TRK_APB_AW-1:0] paddr_i,
  input  logic [`TRK_XLEN-1:0]   pwdata_i,
  output logic [`TRK_XLEN-1:0]   prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  trk_pipe_pkg::retire_rec_t head;
  logic [3:0]                count;
  logic                      overflow;
  logic                      pop;

  trk_retire_if retire_if ();

  trk_pipeline u_pipeline (
    .*,
    .retire (retire_if.pipe_mp)
  );

  trk_retire_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .retire     (retire_if.fifo_mp),
    .pop_i      (pop),
    .head_o     (head),
    .count_o    (count),
    .overflow_o (overflow)
  );

  trk_apb_regs u_apb (
    .*,
    .head_i     (head),
    .count_i    (count),
    .overflow_i (overflow),
    .pop_o      (pop)
  );

endmodule

`default_nettype wire

// ==== rtl/trk_apb_regs.sv ====
// APB readout port
// Zero-wait APB slave exposing the retire queue head, the status word and
// a pop command. The offset is decoded in the setup phase

`default_nettype none

`include "trk_config.svh"

module trk_apb_regs (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`TRK_APB_AW-1:0]    paddr_i,
  input  logic [`TRK_XLEN-1:0]      pwdata_i,
  output logic [`TRK_XLEN-1:0]      prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  input  trk_pipe_pkg::retire_rec_t head_i,
  input  logic [3:0]                count_i,
  input  logic                      overflow_i,
  output logic                      pop_o
);

  trk_apb_pkg::apb_reg_e    sel_q;
  trk_apb_pkg::trk_status_t status;
  logic                     known_q, addr_known, access, is_pop, bad_dir;
  logic [`TRK_XLEN-1:0]     rd_word;

  always_comb begin
    case (paddr_i)
      trk_apb_pkg::REG_STATUS, trk_apb_pkg::REG_PC, trk_apb_pkg::REG_INSTR,
      trk_apb_pkg::REG_RD, trk_apb_pkg::REG_RD_DATA, trk_apb_pkg::REG_MEM_ADDR,
      trk_apb_pkg::REG_MEM_DATA, trk_apb_pkg::REG_POP: addr_known = 1'b1;
      default: addr_known = 1'b0;
    endcase
  end

  // Latch the decode in the setup phase
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      known_q <= 1'b0;
      sel_q   <= trk_apb_pkg::REG_STATUS;
    end else if (psel_i && !penable_i) begin
      known_q <= addr_known;
      sel_q   <= trk_apb_pkg::apb_reg_e'(paddr_i);
    end
  end

  // RD word: misaligned, mem_we, mem_valid, rd_written, then rd_addr at bit 0
  assign rd_word = {{(`TRK_XLEN - `TRK_REG_AW - 4){1'b0}}, head_i.misaligned,
                    head_i.mem_we, head_i.mem_valid, head_i.rd_written, head_i.rd_addr};

  always_comb begin
    status          = '0;
    status.count    = count_i;
    status.overflow = overflow_i;
    status.empty    = (count_i == '0);

    case (sel_q)
      trk_apb_pkg::REG_STATUS:   prdata_o = status;
      trk_apb_pkg::REG_PC:       prdata_o = head_i.pc;
      trk_apb_pkg::REG_INSTR:    prdata_o = head_i.instr;
      trk_apb_pkg::REG_RD:       prdata_o = rd_word;
      trk_apb_pkg::REG_RD_DATA:  prdata_o = head_i.rd_data;
      trk_apb_pkg::REG_MEM_ADDR: prdata_o = head_i.mem_addr;
      trk_apb_pkg::REG_MEM_DATA: prdata_o = head_i.mem_data;
      default:                   prdata_o = '0;
    endcase
  end

  assign access  = psel_i && penable_i;
  assign is_pop  = (sel_q == trk_apb_pkg::REG_POP);
  // Writes only go to POP, and POP is never read
  assign bad_dir = pwrite_i ? !is_pop : is_pop;

  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!known_q || bad_dir);
  // Any pwdata_i value pops the head
  assign pop_o     = access && pwrite_i && known_q && is_pop && (count_i != '0);

endmodule

`default_nettype wire

// ==== rtl/trk_retire_fifo.sv ====
// Retire queue
// Circular buffer taking up to two records per cycle in slot order and
// releasing one per pop. Records that do not fit are dropped and set a
// sticky overflow flag

`default_nettype none

`include "trk_config.svh"

module trk_retire_fifo (
  input  logic                      clk_i,
  input  logic                      rst_n,
  trk_retire_if.fifo_mp             retire,
  input  logic                      pop_i,
  output trk_pipe_pkg::retire_rec_t head_o,
  output logic [3:0]                count_o,
  output logic                      overflow_o
);

  localparam int unsigned DEPTH = `TRK_FIFO_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);

  trk_pipe_pkg::retire_rec_t mem_q [DEPTH];
  logic [PW-1:0] wptr_q, rptr_q;
  logic [3:0]    count_q;
  logic          overflow_q;
  logic          acc0, acc1, pop_ok;

  // Space is judged on the count at the start of the cycle
  always_comb begin
    acc0   = retire.push0_valid && (count_q < 4'(DEPTH));
    acc1   = retire.push1_valid && acc0 && (count_q < 4'(DEPTH - 1));
    pop_ok = pop_i && (count_q != '0);
  end

  always_ff @(posedge clk_i) begin
    if (acc0) begin
      mem_q[wptr_q] <= retire.push0_rec;
    end
    if (acc1) begin
      mem_q[wptr_q + PW'(1)] <= retire.push1_rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      wptr_q  <= wptr_q + PW'(acc0) + PW'(acc1);
      rptr_q  <= rptr_q + PW'(pop_ok);
      count_q <= count_q + 4'(acc0) + 4'(acc1) - 4'(pop_ok);
      if ((retire.push0_valid && !acc0) || (retire.push1_valid && !acc1)) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign head_o     = mem_q[rptr_q];
  assign count_o    = count_q;
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// ==== rtl/trk_pipeline.sv ====
// Pipeline tracker
// Follows each legal decoded instruction through EX, EX-delay, WB and
// WB-delay, collects its first register write, its first memory access and
// a misaligned flag, and pushes the finished record in program order

`default_nettype none

`include "trk_config.svh"

module trk_pipeline (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  logic [`TRK_XLEN-1:0]   pc_i,
  input  logic [`TRK_XLEN-1:0]   instr_i,
  input  logic                   id_valid_i,
  input  logic                   is_decoding_i,
  input  logic                   is_illegal_i,
  input  logic                   ex_valid_i,
  input  logic                   data_misaligned_i,
  input  logic                   apu_en_i,
  input  logic                   apu_rvalid_i,
  input  logic                   ex_reg_we_i,
  input  logic [`TRK_REG_AW-1:0] ex_reg_addr_i,
  input  logic [`TRK_XLEN-1:0]   ex_reg_wdata_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_reg_we_i,
  input  logic [`TRK_REG_AW-1:0] wb_reg_addr_i,
  input  logic [`TRK_XLEN-1:0]   wb_reg_wdata_i,
  input  logic                   ex_data_req_i,
  input  logic                   ex_data_gnt_i,
  input  logic                   ex_data_we_i,
  input  logic [`TRK_XLEN-1:0]   ex_data_addr_i,
  input  logic [`TRK_XLEN-1:0]   ex_data_wdata_i,
  trk_retire_if.pipe_mp          retire
);

  trk_pipe_pkg::slot_t ex_q, exd_q, wb_q, wbd_q;
  trk_pipe_pkg::slot_t ex_upd, exd_upd, wb_upd;
  trk_pipe_pkg::slot_t ex_d, exd_d, wb_d, wbd_d;
  trk_pipe_pkg::slot_t new_slot;
  logic new_instr, wb_go, wb_to_wbd, exd_go;
  logic ex_stall, ex_park, ex_leave, ex_to_exd;

  function automatic trk_pipe_pkg::instr_kind_e classify(logic [`TRK_XLEN-1:0] instr);
    trk_pipe_pkg::instr_kind_e kind;
    kind = trk_pipe_pkg::NORMAL;
    if (instr == `TRK_ENC_MRET || instr == `TRK_ENC_URET || instr == `TRK_ENC_EBREAK ||
        instr[15:0] == `TRK_ENC_C_EBREAK) begin
      kind = trk_pipe_pkg::DELAY;
    end else if (instr[1:0] != 2'b11) begin
      // Compressed: c.lw / c.lwsp and c.sw / c.swsp
      case ({instr[15:13], instr[1:0]})
        5'b010_00, 5'b010_10: kind = trk_pipe_pkg::LOAD;
        5'b110_00, 5'b110_10: kind = trk_pipe_pkg::STORE;
        default:              kind = trk_pipe_pkg::NORMAL;
      endcase
    end else begin
      case (instr[6:0])
        7'b000_0011, 7'b000_0111: kind = trk_pipe_pkg::LOAD;
        7'b010_0011, 7'b010_0111: kind = trk_pipe_pkg::STORE;
        // OP-FP and the fused multiply-add group go to the APU
        7'b101_0011, 7'b100_0011, 7'b100_0111, 7'b100_1011, 7'b100_1111:
          kind = trk_pipe_pkg::APU;
        default: kind = trk_pipe_pkg::NORMAL;
      endcase
    end
    return kind;
  endfunction

  // Only the first register write of an entry is kept
  function automatic trk_pipe_pkg::slot_t attach_reg(trk_pipe_pkg::slot_t s,
                                                     logic [`TRK_REG_AW-1:0] addr,
                                                     logic [`TRK_XLEN-1:0] data);
    trk_pipe_pkg::slot_t r;
    r = s;
    if (!s.rd_written) begin
      r.rd_addr    = addr;
      r.rd_data    = data;
      r.rd_written = 1'b1;
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Advance control
  // --------------------------------------------------------------------------
  always_comb begin
    new_instr = id_valid_i && is_decoding_i && !is_illegal_i;
    wb_go     = wb_q.valid && wb_valid_i;
    wb_to_wbd = wb_go && (wb_q.kind == trk_pipe_pkg::DELAY);
    // Non-APU entries only pass through EX-delay to keep order
    exd_go    = exd_q.valid && (apu_rvalid_i || exd_q.kind != trk_pipe_pkg::APU);
    ex_stall  = ex_valid_i && data_misaligned_i;
    ex_park   = ex_q.valid && ex_valid_i && !ex_stall && apu_en_i && !apu_rvalid_i;
    ex_leave  = ex_q.valid && !ex_stall && !ex_park && ex_valid_i;
    ex_to_exd = ex_park || (ex_leave && exd_go);
  end

  // --------------------------------------------------------------------------
  // Register write, memory and misaligned capture
  // --------------------------------------------------------------------------
  always_comb begin
    ex_upd  = ex_q;
    exd_upd = exd_q;
    wb_upd  = wb_q;

    if (ex_reg_we_i && exd_q.valid && exd_q.kind == trk_pipe_pkg::APU && apu_rvalid_i) begin
      exd_upd = attach_reg(exd_q, ex_reg_addr_i, ex_reg_wdata_i);
    end else if (ex_reg_we_i && ex_q.valid) begin
      ex_upd = attach_reg(ex_q, ex_reg_addr_i, ex_reg_wdata_i);
    end

    if (wb_reg_we_i && wb_q.valid) begin
      wb_upd = attach_reg(wb_q, wb_reg_addr_i, wb_reg_wdata_i);
    end

    if (ex_q.valid && ex_data_req_i && ex_data_gnt_i && !ex_q.mem_valid) begin
      ex_upd.mem_valid = 1'b1;
      ex_upd.mem_we    = ex_data_we_i;
      ex_upd.mem_addr  = ex_data_addr_i;
      ex_upd.mem_data  = ex_data_we_i ? ex_data_wdata_i : '0;
    end

    if (ex_q.valid && ex_stall) begin
      ex_upd.misaligned = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Next slot contents
  // --------------------------------------------------------------------------
  always_comb begin
    new_slot       = '0;
    new_slot.valid = 1'b1;
    new_slot.pc    = pc_i;
    new_slot.instr = instr_i;
    new_slot.kind  = classify(instr_i);

    // WB-delay always empties on the next edge
    wbd_d       = wb_upd;
    wbd_d.valid = wb_to_wbd;

    if (exd_go) begin
      wb_d = exd_upd;
    end else if (ex_leave) begin
      wb_d = ex_upd;
    end else begin
      wb_d       = wb_upd;
      wb_d.valid = wb_q.valid && !wb_go;
    end

    if (ex_to_exd) begin
      exd_d = ex_upd;
    end else begin
      exd_d       = exd_upd;
      exd_d.valid = exd_q.valid && !exd_go;
    end

    if (new_instr) begin
      ex_d = new_slot;
    end else begin
      ex_d       = ex_upd;
      ex_d.valid = ex_q.valid && !ex_park && !ex_leave;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_q.valid  <= 1'b0;
      exd_q.valid <= 1'b0;
      wb_q.valid  <= 1'b0;
      wbd_q.valid <= 1'b0;
    end else begin
      ex_q  <= ex_d;
      exd_q <= exd_d;
      wb_q  <= wb_d;
      wbd_q <= wbd_d;
    end
  end

  // WB-delay is older than WB when both retire on the same edge
  assign retire.push0_valid = wbd_q.valid || (wb_go && !wb_to_wbd);
  assign retire.push0_rec   = wbd_q.valid ? trk_pipe_pkg::slot_to_rec(wbd_q)
                                          : trk_pipe_pkg::slot_to_rec(wb_upd);
  assign retire.push1_valid = wbd_q.valid && wb_go && !wb_to_wbd;
  assign retire.push1_rec   = trk_pipe_pkg::slot_to_rec(wb_upd);

endmodule

`default_nettype wire

// ==== rtl/trk_retire_if.sv ====
// Retire interface
// Carries up to two retire records per cycle from the pipeline tracker to
// the retire queue. Slot 0 is always the older record and slot 1 is only
// valid together with slot 0. There is no back-pressure

`default_nettype none

interface trk_retire_if;

  logic                      push0_valid;
  trk_pipe_pkg::retire_rec_t push0_rec;
  logic                      push1_valid;
  trk_pipe_pkg::retire_rec_t push1_rec;

  modport pipe_mp (
    output push0_valid,
    output push0_rec,
    output push1_valid,
    output push1_rec
  );

  modport fifo_mp (
    input push0_valid,
    input push0_rec,
    input push1_valid,
    input push1_rec
  );

endinterface

`default_nettype wire

// ==== rtl/trk_apb_pkg.sv ====
// Tracker APB types
// Register map of the host readout port and the layout of the status word

`default_nettype none

`include "trk_config.svh"

package trk_apb_pkg;

  typedef enum logic [`TRK_APB_AW-1:0] {
    REG_STATUS   = `TRK_OFS_STATUS,
    REG_PC       = `TRK_OFS_PC,
    REG_INSTR    = `TRK_OFS_INSTR,
    REG_RD       = `TRK_OFS_RD,
    REG_RD_DATA  = `TRK_OFS_RD_DATA,
    REG_MEM_ADDR = `TRK_OFS_MEM_ADDR,
    REG_MEM_DATA = `TRK_OFS_MEM_DATA,
    REG_POP      = `TRK_OFS_POP
  } apb_reg_e;

  // Count sits in the low bits
  typedef struct packed {
    logic [25:0] pad;
    logic        empty;
    logic        overflow;
    logic [3:0]  count;
  } trk_status_t;

endpackage

`default_nettype wire

// ==== rtl/trk_pipe_pkg.sv ====
// Tracker pipeline types
// Tracking slot contents, the retire record pushed into the queue and the
// instruction classes that steer an entry through EX-delay and WB-delay

`default_nettype none

`include "trk_config.svh"

package trk_pipe_pkg;

  // Class of an instruction, fixed when it enters EX
  typedef enum logic [2:0] {
    NORMAL = 3'd0,
    LOAD   = 3'd1,
    STORE  = 3'd2,
    APU    = 3'd3,
    DELAY  = 3'd4
  } instr_kind_e;

  typedef struct packed {
    logic                   valid;
    logic [`TRK_XLEN-1:0]   pc;
    logic [`TRK_XLEN-1:0]   instr;
    instr_kind_e            kind;
    logic [`TRK_REG_AW-1:0] rd_addr;
    logic [`TRK_XLEN-1:0]   rd_data;
    logic                   rd_written;
    logic                   mem_valid;
    logic                   mem_we;
    logic [`TRK_XLEN-1:0]   mem_addr;
    logic [`TRK_XLEN-1:0]   mem_data;
    logic                   misaligned;
  } slot_t;

  // What the queue stores for each retired instruction
  typedef struct packed {
    logic [`TRK_XLEN-1:0]   pc;
    logic [`TRK_XLEN-1:0]   instr;
    logic [`TRK_REG_AW-1:0] rd_addr;
    logic [`TRK_XLEN-1:0]   rd_data;
    logic                   rd_written;
    logic                   mem_valid;
    logic                   mem_we;
    logic [`TRK_XLEN-1:0]   mem_addr;
    logic [`TRK_XLEN-1:0]   mem_data;
    logic                   misaligned;
  } retire_rec_t;

  function automatic retire_rec_t slot_to_rec(slot_t s);
    retire_rec_t r;
    r.pc         = s.pc;
    r.instr      = s.instr;
    r.rd_addr    = s.rd_addr;
    r.rd_data    = s.rd_data;
    r.rd_written = s.rd_written;
    r.mem_valid  = s.mem_valid;
    r.mem_we     = s.mem_we;
    r.mem_addr   = s.mem_addr;
    r.mem_data   = s.mem_data;
    r.misaligned = s.misaligned;
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== include/trk_config.svh ====
// Retirement tracker configuration
// Widths, retire queue depth, APB register offsets and the fixed encodings
// of the instructions that take one extra cycle in writeback

`ifndef TRK_CONFIG_SVH
`define TRK_CONFIG_SVH

`define TRK_XLEN        32
`define TRK_REG_AW      5
`define TRK_FIFO_DEPTH  8
`define TRK_APB_AW      8

// APB byte offsets
`define TRK_OFS_STATUS   8'h00
`define TRK_OFS_PC       8'h04
`define TRK_OFS_INSTR    8'h08
`define TRK_OFS_RD       8'h0C
`define TRK_OFS_RD_DATA  8'h10
`define TRK_OFS_MEM_ADDR 8'h14
`define TRK_OFS_MEM_DATA 8'h18
`define TRK_OFS_POP      8'h1C

// Delay-class instructions
`define TRK_ENC_MRET     32'h3020_0073
`define TRK_ENC_URET     32'h0020_0073
`define TRK_ENC_EBREAK   32'h0010_0073
`define TRK_ENC_C_EBREAK 16'h9002

`endif
